//--- src/bridge_cfg.svh
// Global sizes for the bridge slave. CLKS_PER_BIT is short for simulation only, so raise it for real baud rates
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// --------------------
// Bus side
// --------------------
`define BRIDGE_DATA_W       8       // One data word
`define BRIDGE_ADDR_W       12      // Top bit selects the bridge
`define BRIDGE_LOCAL_DEPTH  2048    // Words behind address bit 11 == 0

// Queue depth, equal to the credits the requester starts with
`define BRIDGE_CREDITS      2

// --------------------
// Link side
// --------------------
`define BRIDGE_CLKS_PER_BIT 8       // Clock cycles per UART bit

`endif

//--- src/bus_pkg.sv
// Bus-side types. Request is write flag, address, data from MSB down; read data is zero on write responses
`include "bridge_cfg.svh"

package bus_pkg;

    // Plain vectors with a meaning
    typedef logic [`BRIDGE_DATA_W-1:0] data_t;        // One data word
    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;        // Full address, MSB = bridge select
    typedef logic [`BRIDGE_ADDR_W-2:0] local_addr_t;  // Address without the select bit

    // Request from the requester, 21 bits
    typedef struct packed {
        logic  write;   // 1 = write, 0 = read
        addr_t addr;
        data_t data;    // Ignored for reads
    } bus_req_t;

    // Response back to the requester, 9 bits
    typedef struct packed {
        logic  write;   // Echo of the request type
        data_t data;    // Read data, zero for writes
    } bus_rsp_t;

endpackage

//--- src/uart_pkg.sv
// Link-side types. Frame fields run mode, data, address from MSB to LSB and are sent LSB first
`include "bridge_cfg.svh"

package uart_pkg;

    // Frame sent to the remote system, 21 bits
    typedef struct packed {
        logic                      mode;  // 1 = write, 0 = read
        logic [`BRIDGE_DATA_W-1:0] data;  // Zero on reads
        logic [`BRIDGE_ADDR_W-1:0] addr;  // Full bus address, select bit included
    } uart_frame_t;

    typedef logic [7:0] uart_byte_t;      // Reply byte for a remote read

    // Bridge engine FSM
    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_tx_wait,
        st_rx_wait
    } bridge_state_e;

endpackage

//--- src/req_queue.sv
// Credit-backed request FIFO. Requester must hold a credit per push; issues one transfer at a time
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module req_queue
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     req_valid,     // Push, spends one credit
    input  bus_req_t req,
    input  logic     slot_free,     // Execute stage finished
    output logic     issue_local,
    output logic     issue_bridge,
    output bus_req_t issue_req
);

    localparam int DEPTH = `BRIDGE_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bus_req_t           fifo [DEPTH];  // Queue storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;         // Entries held
    logic               busy;          // One transfer is out in the execute stage
    logic               push;
    logic               pop;
    bus_req_t           head;

    assign push = req_valid;
    assign pop  = !busy && (count != '0);  // Only when execute stage is free
    assign head = fifo[rd_ptr];

    // --------------------
    // Storage and issued payload
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= req;
        end
        if (pop) begin
            issue_req <= head;     // Held until the next issue
        end
    end

    // --------------------
    // Pointers, count, issue pulses
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            busy         <= 1'b0;
            issue_local  <= 1'b0;
            issue_bridge <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
            // Route on the select bit
            issue_local  <= pop && !head.addr[`BRIDGE_ADDR_W-1];
            issue_bridge <= pop &&  head.addr[`BRIDGE_ADDR_W-1];
            if (pop) begin
                busy <= 1'b1;
            end else if (slot_free) begin
                busy <= 1'b0;              // Response went out, next may issue
            end
        end
    end

    // Requester pushed without holding a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> (count < CNT_W'(DEPTH)));

    a_one_issue: assert property (@(posedge clk) disable iff (!rstn)
        !(issue_local && issue_bridge));

endmodule

//--- src/local_mem.sv
// Local block memory, no reset on contents. Reads of never-written words return X
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module local_mem
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     issue,      // One-cycle access strobe
    input  bus_req_t issue_req,
    output logic     done,       // One cycle after issue
    output bus_rsp_t done_rsp
);

    data_t       mem [`BRIDGE_LOCAL_DEPTH];
    local_addr_t mem_addr;

    assign mem_addr = issue_req.addr[`BRIDGE_ADDR_W-2:0];  // Drop the select bit

    // Memory array and registered response
    always_ff @(posedge clk) begin
        if (issue) begin
            if (issue_req.write) begin
                mem[mem_addr] <= issue_req.data;
            end
            done_rsp.write <= issue_req.write;
            done_rsp.data  <= issue_req.write ? '0 : mem[mem_addr];  // Old value on read
        end
    end

    // Done strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= issue;
        end
    end

endmodule

//--- src/uart_link.sv
// 8N1-style UART, 21-bit TX frames and 8-bit RX bytes. No RX framing error report; a bad stop bit drops the byte
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module uart_link
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        tx_start,   // Only while tx_busy is low
    input  uart_frame_t tx_frame,
    output logic        tx_busy,
    output logic        u_tx,
    input  logic        u_rx,
    output logic        rx_valid,   // One-cycle pulse per byte
    output uart_byte_t  rx_byte
);

    localparam int CPB     = `BRIDGE_CLKS_PER_BIT;
    localparam int CLK_W   = $clog2(CPB);
    localparam int FRAME_W = $bits(uart_frame_t);
    localparam int MID     = CPB / 2 - 1;   // Sample point inside a bit

    // --------------------
    // Transmit
    // --------------------
    logic [FRAME_W:0]          tx_shift;    // Frame plus stop bit
    logic [CLK_W-1:0]          tx_clk_cnt;
    logic [$clog2(FRAME_W+2)-1:0] tx_bit_cnt;  // 0 = start, FRAME_W+1 = stop
    logic                      tx_load;
    logic                      tx_tick;

    assign tx_load = tx_start && !tx_busy;
    assign tx_tick = tx_busy && (tx_clk_cnt == CLK_W'(CPB - 1));  // End of a bit

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_shift <= {1'b1, tx_frame};
        end else if (tx_tick) begin
            tx_shift <= {1'b1, tx_shift[FRAME_W:1]};  // LSB first
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_busy    <= 1'b0;
            u_tx       <= 1'b1;       // Line idles high
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (tx_load) begin
            tx_busy    <= 1'b1;
            u_tx       <= 1'b0;       // Start bit
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (tx_busy) begin
            tx_clk_cnt <= tx_tick ? '0 : tx_clk_cnt + 1'b1;
            if (tx_tick) begin
                if (tx_bit_cnt == ($bits(tx_bit_cnt))'(FRAME_W + 1)) begin
                    tx_busy <= 1'b0;  // Stop bit done
                    u_tx    <= 1'b1;
                end else begin
                    u_tx       <= tx_shift[0];
                    tx_bit_cnt <= tx_bit_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Receive
    // --------------------
    logic             rx_meta;
    logic             rx_sync;     // Synchronized line
    logic             rx_active;
    logic [CLK_W-1:0] rx_clk_cnt;
    logic [3:0]       rx_bit_cnt;  // 0 = start, 1..8 data, 9 = stop
    logic             rx_mid;
    uart_byte_t       rx_shift;

    assign rx_mid  = rx_active && (rx_clk_cnt == CLK_W'(MID));
    assign rx_byte = rx_shift;     // Stable in the rx_valid cycle

    always_ff @(posedge clk) begin
        if (rx_mid && (rx_bit_cnt >= 4'd1) && (rx_bit_cnt <= 4'd8)) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            rx_active  <= 1'b0;
            rx_clk_cnt <= '0;
            rx_bit_cnt <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_meta  <= u_rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            if (!rx_active) begin
                if (!rx_sync) begin    // Falling edge, start bit
                    rx_active  <= 1'b1;
                    rx_clk_cnt <= '0;
                    rx_bit_cnt <= '0;
                end
            end else begin
                rx_clk_cnt <= (rx_clk_cnt == CLK_W'(CPB - 1)) ? '0 : rx_clk_cnt + 1'b1;
                if (rx_mid) begin
                    if ((rx_bit_cnt == 4'd0) && rx_sync) begin
                        rx_active <= 1'b0;        // Glitch, not a start bit
                    end else if (rx_bit_cnt == 4'd9) begin
                        rx_active <= 1'b0;
                        rx_valid  <= rx_sync;     // Good stop bit
                    end else begin
                        rx_bit_cnt <= rx_bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Engine must wait for the previous frame to leave
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        tx_busy |-> !tx_start);

endmodule

//--- src/bridge_engine.sv
// Bridge FSM, one transfer at a time. A read waits forever for its reply byte; there is no timeout
`timescale 1ns/1ps

module bridge_engine
    import bus_pkg::*;
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        issue,
    input  bus_req_t    issue_req,
    output logic        tx_start,
    output uart_frame_t tx_frame,
    input  logic        tx_busy,
    input  logic        rx_valid,
    input  uart_byte_t  rx_byte,
    output logic        done,
    output bus_rsp_t    done_rsp
);

    bridge_state_e state;
    bus_req_t      req_q;      // Latched request
    logic          tx_seen;    // tx_busy has gone high for this frame
    logic          wr_finish;
    logic          rd_finish;
    logic          tx_end;

    // Frame is mode, data, address; reads carry zero data
    assign tx_frame.mode = req_q.write;
    assign tx_frame.data = req_q.write ? req_q.data : '0;
    assign tx_frame.addr = req_q.addr;

    assign tx_start  = (state == st_send) && !tx_busy;
    assign tx_end    = (state == st_tx_wait) && tx_seen && !tx_busy;  // Stop bit sent
    assign wr_finish = tx_end && req_q.write;
    assign rd_finish = (state == st_rx_wait) && rx_valid;             // Late bytes ignored

    // --------------------
    // Payload
    // --------------------
    always_ff @(posedge clk) begin
        if ((state == st_idle) && issue) begin
            req_q <= issue_req;
        end
        if (wr_finish) begin
            done_rsp.write <= 1'b1;
            done_rsp.data  <= '0;
        end else if (rd_finish) begin
            done_rsp.write <= 1'b0;
            done_rsp.data  <= rx_byte;
        end
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            tx_seen <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= wr_finish || rd_finish;
            case (state)
                st_idle: begin
                    if (issue) begin
                        state <= st_send;
                    end
                end
                st_send: begin
                    tx_seen <= 1'b0;
                    if (tx_start) begin
                        state <= st_tx_wait;
                    end
                end
                st_tx_wait: begin
                    if (tx_busy) begin
                        tx_seen <= 1'b1;
                    end
                    if (tx_end) begin
                        state <= req_q.write ? st_idle : st_rx_wait;
                    end
                end
                st_rx_wait: begin
                    if (rx_valid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- src/rsp_return.sv
// Response merge, purely combinational. clk feeds only the check that the execute stages never finish together
`timescale 1ns/1ps

module rsp_return
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     local_done,
    input  logic     bridge_done,
    input  bus_rsp_t local_rsp,
    input  bus_rsp_t bridge_rsp,
    output logic     rsp_valid,
    output bus_rsp_t rsp,
    output logic     credit_return,
    output logic     slot_free
);

    // Only one transfer is in execute, so at most one done
    assign rsp_valid     = local_done || bridge_done;
    assign rsp           = bridge_done ? bridge_rsp : local_rsp;
    assign credit_return = rsp_valid;   // Requester gets its credit back
    assign slot_free     = rsp_valid;   // Queue may issue the next one

    a_one_done: assert property (@(posedge clk)
        !(local_done && bridge_done));

endmodule

//--- src/bus_bridge_slave.sv
// Bus slave top. Address bit 11 low goes to local memory, high goes over the UART link
`timescale 1ns/1ps

module bus_bridge_slave
    import bus_pkg::*;
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     credit_return,
    output logic     rsp_valid,
    output bus_rsp_t rsp,
    output logic     u_tx,
    input  logic     u_rx
);

    // --------------------
    // Pipeline wires
    // --------------------
    logic        issue_local;
    logic        issue_bridge;
    bus_req_t    issue_req;     // Shared by both execute stages
    logic        slot_free;
    logic        local_done;
    bus_rsp_t    local_rsp;
    logic        bridge_done;
    bus_rsp_t    bridge_rsp;
    logic        tx_start;      // Engine to link
    uart_frame_t tx_frame;
    logic        tx_busy;
    logic        rx_valid;
    uart_byte_t  rx_byte;

    req_queue u_req_queue (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req          (req),
        .slot_free    (slot_free),
        .issue_local  (issue_local),
        .issue_bridge (issue_bridge),
        .issue_req    (issue_req)
    );

    local_mem u_local_mem (
        .clk       (clk),
        .rstn      (rstn),
        .issue     (issue_local),
        .issue_req (issue_req),
        .done      (local_done),
        .done_rsp  (local_rsp)
    );

    bridge_engine u_bridge_engine (
        .clk       (clk),
        .rstn      (rstn),
        .issue     (issue_bridge),
        .issue_req (issue_req),
        .tx_start  (tx_start),
        .tx_frame  (tx_frame),
        .tx_busy   (tx_busy),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .done      (bridge_done),
        .done_rsp  (bridge_rsp)
    );

    uart_link u_uart_link (
        .clk      (clk),
        .rstn     (rstn),
        .tx_start (tx_start),
        .tx_frame (tx_frame),
        .tx_busy  (tx_busy),
        .u_tx     (u_tx),
        .u_rx     (u_rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    rsp_return u_rsp_return (
        .clk           (clk),
        .local_done    (local_done),
        .bridge_done   (bridge_done),
        .local_rsp     (local_rsp),
        .bridge_rsp    (bridge_rsp),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .credit_return (credit_return),
        .slot_free     (slot_free)
    );

endmodule

//--- tests/tb_remote_model.sv
// Remote system model. Frames are sampled on falling clock edges; a read reply goes out two idle bit times after the stop bit
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_remote_model
    import uart_pkg::*;
(
    input  logic clk,
    input  logic u_tx,     // From the DUT
    output logic u_rx      // To the DUT
);

    localparam int CPB = `BRIDGE_CLKS_PER_BIT;
    localparam int FW  = $bits(uart_frame_t);

    uart_byte_t  mem [4096];   // Remote storage, whole address space
    logic [FW-1:0] bits;
    uart_frame_t frame;

    // Serial byte out, start bit, LSB first, one stop bit
    task automatic send_byte(input uart_byte_t b);
        u_rx = 1'b0;
        repeat (CPB) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            u_rx = b[i];
            repeat (CPB) @(negedge clk);
        end
        u_rx = 1'b1;
        repeat (CPB) @(negedge clk);
    endtask

    initial begin
        u_rx = 1'b1;              // Line idles high
        for (int i = 0; i < 4096; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(negedge u_tx);                   // Start bit begins
            repeat (CPB / 2) @(negedge clk);   // Middle of the start bit
            for (int i = 0; i < FW; i++) begin
                repeat (CPB) @(negedge clk);
                bits[i] = u_tx;                // Address first, mode last
            end
            repeat (CPB) @(negedge clk);       // Middle of the stop bit
            frame = uart_frame_t'(bits);
            if (frame.mode) begin
                mem[frame.addr] = frame.data;
            end else begin
                repeat (2 * CPB) @(negedge clk);  // Two idle bit times
                send_byte(mem[frame.addr]);
            end
        end
    end

endmodule

//--- tests/tb_bus_bridge_slave.sv
// Requests are driven under credits on falling edges; local reads only target addresses written earlier in the run
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_bus_bridge_slave
    import bus_pkg::*;
();

    localparam int CREDITS  = `BRIDGE_CREDITS;
    localparam int N_RANDOM = 40;
    localparam int SEL      = `BRIDGE_ADDR_W - 1;   // Bridge select bit

    logic     clk;
    logic     rstn;
    logic     req_valid;
    bus_req_t req;
    logic     credit_return;
    logic     rsp_valid;
    bus_rsp_t rsp;
    logic     u_tx;
    logic     u_rx;

    bus_req_t stim_q [$];       // Whole run, built up front
    bus_rsp_t exp_q [$];        // Expected responses in request order
    data_t    ref_mem [4096];   // Reference for both address halves
    bit       local_written [`BRIDGE_LOCAL_DEPTH];
    int       credits;          // Credits the requester holds
    int       cycles;
    int       limit;

    bus_bridge_slave bus_bridge_slave_inst (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .u_tx          (u_tx),
        .u_rx          (u_rx)
    );

    tb_remote_model u_remote (.clk(clk), .u_tx(u_tx), .u_rx(u_rx));

    always #50 clk = ~clk;   // 100 ns period

    // --------------------
    // Checks
    // --------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic compare_rsp(input bus_rsp_t exp, input bus_rsp_t got);
        if (got !== exp) begin
            report_fail($sformatf("ERROR %0d ns: rsp expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic compare_credit(input int cnt, input bit at_end);
        if ((cnt < 0) || (cnt > CREDITS)) begin
            report_fail($sformatf("Credit count left its range at %0d ns, now %0d", $time, cnt));
        end else if (at_end && (cnt != CREDITS)) begin
            report_fail($sformatf("ERROR %0d ns: credits expected %0d got %0d",
                                  $time, CREDITS, cnt));
        end
    endtask

    // Reads return the last value written, writes return zero data
    function automatic bus_rsp_t expected_rsp(input bus_req_t r);
        bus_rsp_t e;
        e.write = r.write;
        if (r.write) begin
            ref_mem[r.addr] = r.data;
            e.data          = '0;
        end else begin
            e.data = ref_mem[r.addr];
        end
        return e;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic add_req(input logic write, input addr_t addr, input data_t data);
        bus_req_t r;
        r.write = write;
        r.addr  = addr;
        r.data  = data;
        stim_q.push_back(r);
        if (write && !addr[SEL]) begin
            local_written[addr[SEL-1:0]] = 1'b1;
        end
    endtask

    // Called on a falling edge, waits for a credit first
    task automatic send_req(input bus_req_t r);
        while (credits == 0) begin
            @(negedge clk);
        end
        req_valid = 1'b1;
        req       = r;
        credits--;
        exp_q.push_back(expected_rsp(r));
        @(negedge clk);
        req_valid = 1'b0;   // Next call may raise it again at once
    endtask

    // Response and credit monitor
    always @(posedge clk) begin
        if (rstn && rsp_valid) begin
            if (exp_q.size() == 0) begin
                report_fail("A response arrived with no request outstanding");
            end else begin
                compare_rsp(exp_q.pop_front(), rsp);
            end
        end
        if (rstn && credit_return) begin
            credits++;
            compare_credit(credits, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            report_fail($sformatf("Timeout after %0d cycles, responses stopped arriving", cycles));
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        bus_req_t r;
        int       n_bridge;
        void'($urandom(32'h8dc4));
        clk        = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        credits    = CREDITS;
        cycles     = 0;
        n_bridge   = 0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = '0;   // Remote model starts at zero too
        end
        add_req(1'b1, 12'h123, 8'h5a);   // Local write then read
        add_req(1'b0, 12'h123, 8'h00);
        add_req(1'b1, 12'h9c4, 8'ha7);   // Bridge write then read
        add_req(1'b0, 12'h9c4, 8'h00);
        add_req(1'b1, 12'h2f0, 8'h3c);   // Same low bits on both sides
        add_req(1'b1, 12'haf0, 8'hc3);
        add_req(1'b0, 12'h2f0, 8'h00);
        add_req(1'b0, 12'haf0, 8'h00);
        add_req(1'b0, 12'h123, 8'h00);   // Mixed back to back
        add_req(1'b0, 12'h9c4, 8'h00);
        for (int i = 0; i < N_RANDOM; i++) begin
            r.write = 1'($urandom);
            r.addr  = addr_t'($urandom);
            r.data  = data_t'($urandom);
            if (!r.write && !r.addr[SEL] && !local_written[r.addr[SEL-1:0]]) begin
                r.write = 1'b1;   // Unwritten local word holds X
            end
            add_req(r.write, r.addr, r.data);
        end
        foreach (stim_q[i]) begin
            if (stim_q[i].addr[SEL]) begin
                n_bridge++;
            end
        end
        limit = n_bridge * 30 * `BRIDGE_CLKS_PER_BIT + 2000;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);
        foreach (stim_q[i]) begin
            send_req(stim_q[i]);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);   // Drain, timeout guards this
        end
        compare_credit(credits, 1'b1);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/bus_pkg.sv
src/uart_pkg.sv
src/req_queue.sv
src/local_mem.sv
src/uart_link.sv
src/bridge_engine.sv
src/rsp_return.sv
src/bus_bridge_slave.sv
tests/tb_remote_model.sv
tests/tb_bus_bridge_slave.sv
